/* ts_pkg.sv */
`default_nettype none

package ts_pkg;

	// MPEG-TS packet framing
	localparam int ts_pkt_bytes = 188;
	localparam logic [7:0] ts_sync_byte = 8'h47;
	localparam int ts_pkt_words = ts_pkt_bytes / 4;

	// PID is 13 bits spread over header bytes 1 and 2
	localparam int ts_pid_bits = 13;

	// replacer stages ahead of the output select register
	localparam int ts_repl_latency = 3;

	// index widths derived from the packet size
	localparam int ts_byte_idx_bits = $clog2(ts_pkt_bytes);
	localparam int ts_word_idx_bits = $clog2(ts_pkt_words);

endpackage

`default_nettype wire

/* tsp_regs_pkg.sv */
`default_nettype none

package tsp_regs_pkg;

	localparam int reg_addr_bits = 8;
	localparam int reg_data_bits = 32;

	// register map
	localparam logic [reg_addr_bits-1:0] addr_slot = 8'd0;
	localparam logic [reg_addr_bits-1:0] addr_pid = 8'd1;
	localparam logic [reg_addr_bits-1:0] addr_match_enable = 8'd2;
	localparam logic [reg_addr_bits-1:0] addr_dump = 8'd3;
	localparam logic [reg_addr_bits-1:0] addr_matched_count = 8'd4;
	localparam logic [reg_addr_bits-1:0] addr_data_base = 8'd128;
	localparam logic [reg_addr_bits-1:0] addr_data_last =
		addr_data_base + reg_addr_bits'(ts_pkg::ts_pkt_words - 1);

	// slot 0 is the monitor, the rest are replacers
	localparam int num_replacers = 2;
	localparam int num_slots = num_replacers + 1;
	localparam int slot_bits = $clog2(num_slots);
	localparam int rep_bits = $clog2(num_replacers);

	// upper half of an unmapped read
	localparam logic [15:0] unmapped_tag = 16'hE000;

	// pid register, stored raw, decoded by the filters
	typedef struct packed {
		logic [14:0] rsvd_hi;
		logic pid_valid;
		logic [2:0] rsvd_lo;
		logic [ts_pkg::ts_pid_bits-1:0] pid;
	} pid_fields_t;

	typedef union packed {
		logic [reg_data_bits-1:0] raw;
		pid_fields_t f;
	} pid_word_t;

endpackage

`default_nettype wire

/* ts_monitor.sv */
`default_nettype none

module ts_monitor (
	input wire clk,
	input wire rst_n,
	input wire [7:0] ts_in_data,
	input wire ts_in_valid,
	input wire ts_in_sync,
	input wire tsp_regs_pkg::pid_word_t pid_word,
	input wire match_enable,
	input wire dump_req,
	output logic [tsp_regs_pkg::reg_data_bits-1:0] matched_count,
	output logic dump_ack,
	output logic dump_valid,
	output logic [ts_pkg::ts_word_idx_bits-1:0] dump_index,
	output logic [tsp_regs_pkg::reg_data_bits-1:0] dump_data
);
	import ts_pkg::*;
	import tsp_regs_pkg::*;

	localparam logic [ts_word_idx_bits-1:0] last_word = ts_word_idx_bits'(ts_pkt_words - 1);

	logic [reg_data_bits-1:0] cap_mem [ts_pkt_words];
	logic [ts_byte_idx_bits-1:0] byte_cnt;
	logic [ts_byte_idx_bits-1:0] cur_idx;
	logic [7:0] hdr0;
	logic [7:0] hdr1;
	logic match;
	logic capturing;
	logic dumping;
	logic [ts_word_idx_bits-1:0] rd_idx;

	assign cur_idx = ts_in_sync ? '0 : byte_cnt;
	// pid complete once byte 2 arrives
	assign match = ts_in_valid && cur_idx == 2 && match_enable && pid_word.f.pid_valid &&
		{hdr1[ts_pid_bits-9:0], ts_in_data} == pid_word.f.pid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_cnt <= ts_byte_idx_bits'(ts_pkt_bytes);
			capturing <= 1'b0;
			matched_count <= '0;
			dumping <= 1'b0;
			rd_idx <= '0;
			dump_valid <= 1'b0;
			dump_ack <= 1'b0;
		end else begin
			if (ts_in_valid && cur_idx < ts_byte_idx_bits'(ts_pkt_bytes)) begin
				byte_cnt <= cur_idx + 1'b1;
			end
			if (ts_in_valid && cur_idx == 2) begin
				capturing <= match;
			end
			if (match) begin
				matched_count <= matched_count + 1'b1;
			end
			dump_valid <= 1'b0;
			if (dump_ack) begin
				if (!dump_req) begin
					dump_ack <= 1'b0;
				end
			end else if (dumping) begin
				dump_valid <= 1'b1;
				if (rd_idx == last_word) begin
					dumping <= 1'b0;
					dump_ack <= 1'b1;
				end else begin
					rd_idx <= rd_idx + 1'b1;
				end
			end else if (dump_req) begin
				dumping <= 1'b1;
				rd_idx <= '0;
			end
		end
	end

	// little-endian packing, byte 4w lands in bits 7:0 of word w
	always_ff @(posedge clk) begin
		if (ts_in_valid && cur_idx == 0) begin
			hdr0 <= ts_in_data;
		end
		if (ts_in_valid && cur_idx == 1) begin
			hdr1 <= ts_in_data;
		end
		if (match) begin
			cap_mem[0][7:0] <= hdr0;
			cap_mem[0][15:8] <= hdr1;
			cap_mem[0][23:16] <= ts_in_data;
		end else if (capturing && ts_in_valid && cur_idx > 2 &&
				cur_idx < ts_byte_idx_bits'(ts_pkt_bytes)) begin
			cap_mem[cur_idx[ts_byte_idx_bits-1:2]][{cur_idx[1:0], 3'b000} +: 8] <= ts_in_data;
		end
		dump_index <= rd_idx;
		dump_data <= cap_mem[rd_idx];
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		dump_valid |-> dump_req);

endmodule

`default_nettype wire

/* ts_replacer.sv */
`default_nettype none

module ts_replacer (
	input wire clk,
	input wire rst_n,
	input wire [7:0] ts_in_data,
	input wire ts_in_valid,
	input wire ts_in_sync,
	input wire tsp_regs_pkg::pid_word_t pid_word,
	input wire match_enable,
	input wire load_word,
	input wire [ts_pkg::ts_word_idx_bits-1:0] load_index,
	input wire [tsp_regs_pkg::reg_data_bits-1:0] load_data,
	output logic [7:0] out_data,
	output logic out_valid,
	output logic out_sync,
	output logic hit,
	output logic [tsp_regs_pkg::reg_data_bits-1:0] matched_count
);
	import ts_pkg::*;
	import tsp_regs_pkg::*;

	localparam int last_st = ts_repl_latency - 1;

	logic [reg_data_bits-1:0] rep_mem [ts_pkt_words];
	logic [ts_byte_idx_bits-1:0] byte_cnt;
	logic [ts_byte_idx_bits-1:0] cur_idx;
	logic [7:0] st_data [ts_repl_latency];
	logic [ts_byte_idx_bits-1:0] st_idx [ts_repl_latency];
	logic [ts_repl_latency-1:0] st_valid;
	logic [ts_repl_latency-1:0] st_sync;
	logic [ts_repl_latency-1:0] st_hit;
	logic pkt_hit;
	logic decide;
	logic match_now;
	logic in_hit;
	logic last_hit;
	logic [ts_pid_bits-1:0] pid_seen;
	logic [7:0] rep_byte;

	assign cur_idx = ts_in_sync ? '0 : byte_cnt;

	// byte 2 in stage 0, byte 1 in stage 1
	assign decide = st_valid[0] && st_idx[0] == 2;
	assign pid_seen = {st_data[1][ts_pid_bits-9:0], st_data[0]};
	assign match_now = decide && match_enable && pid_word.f.pid_valid &&
		pid_seen == pid_word.f.pid;

	// later bytes of the packet take the fresh decision or the held one
	assign in_hit = ts_in_valid && cur_idx > 2 && cur_idx < ts_byte_idx_bits'(ts_pkt_bytes) &&
		(decide ? match_now : pkt_hit);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_cnt <= ts_byte_idx_bits'(ts_pkt_bytes);
			st_valid <= '0;
			st_sync <= '0;
			st_hit <= '0;
			pkt_hit <= 1'b0;
			matched_count <= '0;
		end else begin
			if (ts_in_valid && cur_idx < ts_byte_idx_bits'(ts_pkt_bytes)) begin
				byte_cnt <= cur_idx + 1'b1;
			end
			st_valid <= {st_valid[last_st-1:0], ts_in_valid};
			st_sync <= {st_sync[last_st-1:0], ts_in_sync};
			// header bytes already in flight pick up the decision as they shift
			st_hit <= {st_hit[last_st-1:0] | {last_st{match_now}}, in_hit};
			if (decide) begin
				pkt_hit <= match_now;
			end
			if (match_now) begin
				matched_count <= matched_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		st_data[0] <= ts_in_data;
		st_idx[0] <= cur_idx;
		for (int k = 1; k < ts_repl_latency; k++) begin
			st_data[k] <= st_data[k-1];
			st_idx[k] <= st_idx[k-1];
		end
	end

	always_ff @(posedge clk) begin
		if (load_word) begin
			rep_mem[load_index] <= load_data;
		end
	end

	// byte 0 sits in the last stage while the decision is made
	assign last_hit = st_hit[last_st] || (match_now && st_idx[last_st] == 0);
	assign rep_byte = rep_mem[st_idx[last_st][ts_byte_idx_bits-1:2]]
		[{st_idx[last_st][1:0], 3'b000} +: 8];

	always_comb begin
		out_data = st_data[last_st];
		if (last_hit) begin
			out_data = (st_idx[last_st] == 0) ? ts_sync_byte : rep_byte;
		end
	end

	assign hit = st_valid[last_st] && last_hit;
	assign out_valid = st_valid[last_st];
	assign out_sync = st_sync[last_st];

	assert property (@(posedge clk) disable iff (!rst_n)
		ts_in_sync |-> ts_in_valid);

endmodule

`default_nettype wire

/* tsp_ram.sv */
`default_nettype none

module tsp_ram (
	input wire clk,
	input wire rst_n,
	input wire wen,
	input wire [tsp_regs_pkg::reg_addr_bits-1:0] waddr,
	input wire [tsp_regs_pkg::reg_data_bits-1:0] wdata,
	input wire ren,
	input wire [tsp_regs_pkg::reg_addr_bits-1:0] raddr,
	output logic [tsp_regs_pkg::reg_data_bits-1:0] rdata,
	input wire [tsp_regs_pkg::reg_data_bits-1:0] mon_matched_count,
	input wire dump_ack,
	input wire dump_valid,
	input wire [ts_pkg::ts_word_idx_bits-1:0] dump_index,
	input wire [tsp_regs_pkg::reg_data_bits-1:0] dump_data,
	input wire [tsp_regs_pkg::reg_data_bits-1:0] rep_matched_count [tsp_regs_pkg::num_replacers],
	input wire [7:0] rep_data [tsp_regs_pkg::num_replacers],
	input wire [tsp_regs_pkg::num_replacers-1:0] rep_valid,
	input wire [tsp_regs_pkg::num_replacers-1:0] rep_sync,
	input wire [tsp_regs_pkg::num_replacers-1:0] rep_hit,
	output tsp_regs_pkg::pid_word_t pid_word [tsp_regs_pkg::num_slots],
	output logic [tsp_regs_pkg::num_slots-1:0] match_enable,
	output logic [tsp_regs_pkg::num_replacers-1:0] load_word,
	output logic [ts_pkg::ts_word_idx_bits-1:0] load_index,
	output logic [tsp_regs_pkg::reg_data_bits-1:0] load_data,
	output logic dump_req,
	output logic [7:0] ts_out,
	output logic ts_out_valid,
	output logic ts_out_sync
);
	import ts_pkg::*;
	import tsp_regs_pkg::*;

	logic [slot_bits-1:0] current_slot;
	logic [rep_bits-1:0] rep_sel;
	logic [rep_bits-1:0] out_sel;
	logic [reg_data_bits-1:0] win_mem [ts_pkt_words];
	logic wr_window;
	logic rd_window;
	logic [ts_word_idx_bits-1:0] wr_word;
	logic [ts_word_idx_bits-1:0] rd_word;
	logic dump_busy;

	// slots 1.. map onto replacers 0..
	assign rep_sel = rep_bits'(current_slot - 1'b1);
	assign wr_window = waddr >= addr_data_base && waddr <= addr_data_last;
	assign rd_window = raddr >= addr_data_base && raddr <= addr_data_last;
	assign wr_word = ts_word_idx_bits'(waddr - addr_data_base);
	assign rd_word = ts_word_idx_bits'(raddr - addr_data_base);
	assign dump_busy = dump_req || dump_ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			current_slot <= '0;
			match_enable <= '0;
			load_word <= '0;
			dump_req <= 1'b0;
			for (int i = 0; i < num_slots; i++) begin
				pid_word[i] <= '0;
			end
		end else begin
			load_word <= '0;
			// handshake closes once the monitor acks
			if (dump_req && dump_ack) begin
				dump_req <= 1'b0;
			end
			if (wen) begin
				case (waddr)
					addr_slot: begin
						if (wdata < num_slots) begin
							current_slot <= slot_bits'(wdata);
						end
					end
					addr_pid: begin
						pid_word[current_slot].raw <= wdata;
					end
					addr_match_enable: begin
						match_enable[current_slot] <= wdata[0];
					end
					addr_dump: begin
						if (current_slot == '0 && !dump_busy) begin
							dump_req <= 1'b1;
						end
					end
					default: begin
						if (wr_window && current_slot != '0) begin
							load_word[rep_sel] <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wen && wr_window) begin
			load_index <= wr_word;
			load_data <= wdata;
		end
	end

	// capture copy from the monitor
	always_ff @(posedge clk) begin
		if (dump_req && dump_valid) begin
			win_mem[dump_index] <= dump_data;
		end
	end

	always_ff @(posedge clk) begin
		if (ren) begin
			case (raddr)
				addr_slot: rdata <= reg_data_bits'(current_slot);
				addr_pid: rdata <= pid_word[current_slot].raw;
				addr_match_enable: rdata <= reg_data_bits'(match_enable[current_slot]);
				addr_dump: rdata <= reg_data_bits'(dump_busy);
				addr_matched_count: begin
					if (current_slot == '0) begin
						rdata <= mon_matched_count;
					end else begin
						rdata <= rep_matched_count[rep_sel];
					end
				end
				default: begin
					if (rd_window) begin
						rdata <= win_mem[rd_word];
					end else begin
						rdata <= {unmapped_tag, {(16 - reg_addr_bits){1'b0}}, raddr};
					end
				end
			endcase
		end
	end

	// lowest hit replacer wins over the original from replacer 0
	always_comb begin
		out_sel = '0;
		for (int i = num_replacers - 1; i >= 0; i--) begin
			if (rep_hit[i]) begin
				out_sel = rep_bits'(i);
			end
		end
	end

	// valid and sync run alongside the data in every replacer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ts_out_valid <= 1'b0;
			ts_out_sync <= 1'b0;
		end else begin
			ts_out_valid <= rep_valid[0];
			ts_out_sync <= rep_sync[0];
		end
	end

	always_ff @(posedge clk) begin
		ts_out <= rep_data[out_sel];
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		$fell(dump_req) |-> dump_ack);

endmodule

`default_nettype wire

/* tsp_top.sv */
`default_nettype none

module tsp_top (
	input wire clk,
	input wire rst_n,
	input wire wen,
	input wire [tsp_regs_pkg::reg_addr_bits-1:0] waddr,
	input wire [tsp_regs_pkg::reg_data_bits-1:0] wdata,
	input wire ren,
	input wire [tsp_regs_pkg::reg_addr_bits-1:0] raddr,
	output logic [tsp_regs_pkg::reg_data_bits-1:0] rdata,
	input wire [7:0] ts_in_data,
	input wire ts_in_valid,
	input wire ts_in_sync,
	output logic [7:0] ts_out,
	output logic ts_out_valid,
	output logic ts_out_sync
);
	import ts_pkg::*;
	import tsp_regs_pkg::*;

	pid_word_t pid_word [num_slots];
	logic [num_slots-1:0] match_enable;
	logic [num_replacers-1:0] load_word;
	logic [ts_word_idx_bits-1:0] load_index;
	logic [reg_data_bits-1:0] load_data;
	logic dump_req;
	logic dump_ack;
	logic dump_valid;
	logic [ts_word_idx_bits-1:0] dump_index;
	logic [reg_data_bits-1:0] dump_data;
	logic [reg_data_bits-1:0] mon_matched_count;
	logic [reg_data_bits-1:0] rep_matched_count [num_replacers];
	logic [7:0] rep_data [num_replacers];
	logic [num_replacers-1:0] rep_valid;
	logic [num_replacers-1:0] rep_sync;
	logic [num_replacers-1:0] rep_hit;

	tsp_ram u_ram (
		.clk(clk), .rst_n(rst_n),
		.wen(wen), .waddr(waddr), .wdata(wdata),
		.ren(ren), .raddr(raddr), .rdata(rdata),
		.mon_matched_count(mon_matched_count),
		.dump_ack(dump_ack), .dump_valid(dump_valid),
		.dump_index(dump_index), .dump_data(dump_data),
		.rep_matched_count(rep_matched_count), .rep_data(rep_data),
		.rep_valid(rep_valid), .rep_sync(rep_sync), .rep_hit(rep_hit),
		.pid_word(pid_word), .match_enable(match_enable),
		.load_word(load_word), .load_index(load_index), .load_data(load_data),
		.dump_req(dump_req),
		.ts_out(ts_out), .ts_out_valid(ts_out_valid), .ts_out_sync(ts_out_sync)
	);

	ts_monitor u_monitor (
		.clk(clk), .rst_n(rst_n),
		.ts_in_data(ts_in_data), .ts_in_valid(ts_in_valid), .ts_in_sync(ts_in_sync),
		.pid_word(pid_word[0]), .match_enable(match_enable[0]),
		.dump_req(dump_req), .matched_count(mon_matched_count),
		.dump_ack(dump_ack), .dump_valid(dump_valid),
		.dump_index(dump_index), .dump_data(dump_data)
	);

	// replacer g serves slot g + 1
	for (genvar g = 0; g < num_replacers; g++) begin : g_rep
		ts_replacer u_replacer (
			.clk(clk), .rst_n(rst_n),
			.ts_in_data(ts_in_data), .ts_in_valid(ts_in_valid), .ts_in_sync(ts_in_sync),
			.pid_word(pid_word[g + 1]), .match_enable(match_enable[g + 1]),
			.load_word(load_word[g]), .load_index(load_index), .load_data(load_data),
			.out_data(rep_data[g]), .out_valid(rep_valid[g]), .out_sync(rep_sync[g]),
			.hit(rep_hit[g]), .matched_count(rep_matched_count[g])
		);
	end

endmodule

`default_nettype wire

/* tb_tsp.sv */
`default_nettype none

module tb_tsp;
	timeunit 1ns;
	timeprecision 1ps;
	import ts_pkg::*;
	import tsp_regs_pkg::*;

	localparam int cycles_per_line = 400;

	logic clk;
	logic rst_n;
	logic wen;
	logic [reg_addr_bits-1:0] waddr;
	logic [reg_data_bits-1:0] wdata;
	logic ren;
	logic [reg_addr_bits-1:0] raddr;
	logic [reg_data_bits-1:0] rdata;
	logic [7:0] ts_in_data;
	logic ts_in_valid;
	logic ts_in_sync;
	logic [7:0] ts_out;
	logic ts_out_valid;
	logic ts_out_sync;

	// host-side mirror of the register file
	logic [slot_bits-1:0] slot_m;
	pid_word_t pid_m [num_slots];
	logic [num_slots-1:0] en_m;
	logic [reg_data_bits-1:0] rep_m [num_replacers][ts_pkt_words];
	logic [7:0] cap_m [ts_pkt_bytes];
	// entries are {valid, sync, data}
	logic [9:0] pkt_q [$];
	logic [9:0] line_q [$];
	int limit_cycles = 0;

	tsp_top i_dut (
		.clk(clk), .rst_n(rst_n),
		.wen(wen), .waddr(waddr), .wdata(wdata),
		.ren(ren), .raddr(raddr), .rdata(rdata),
		.ts_in_data(ts_in_data), .ts_in_valid(ts_in_valid), .ts_in_sync(ts_in_sync),
		.ts_out(ts_out), .ts_out_valid(ts_out_valid), .ts_out_sync(ts_out_sync)
	);

	always #10 clk = ~clk;

	task automatic check_word(input string name, input logic [reg_data_bits-1:0] exp,
		input logic [reg_data_bits-1:0] act);
		if (act !== exp) begin
			$display("ERROR: t=%0t %s expected %h got %h", $time, name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1, "register word mismatch");
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("ERROR: t=%0t %s expected %h got %h", $time, name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1, "stream byte mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR: t=%0t %s expected %b got %b", $time, name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1, "stream flag mismatch");
		end
	endtask

	task automatic write_reg(input logic [reg_addr_bits-1:0] addr,
		input logic [reg_data_bits-1:0] data);
		@(posedge clk);
		wen <= 1'b1;
		waddr <= addr;
		wdata <= data;
		@(posedge clk);
		wen <= 1'b0;
		if (addr == addr_slot && data < num_slots) begin
			slot_m = slot_bits'(data);
		end else if (addr == addr_pid) begin
			pid_m[slot_m].raw = data;
		end else if (addr == addr_match_enable) begin
			en_m[slot_m] = data[0];
		end else if (addr >= addr_data_base && addr <= addr_data_last && slot_m != 0) begin
			rep_m[slot_m - 1][addr - addr_data_base] = data;
		end
	endtask

	task automatic read_reg(input logic [reg_addr_bits-1:0] addr,
		output logic [reg_data_bits-1:0] data);
		@(posedge clk);
		ren <= 1'b1;
		raddr <= addr;
		@(posedge clk);
		ren <= 1'b0;
		@(negedge clk);
		data = rdata;
	endtask

	// pattern mixes every address bit into each byte lane
	task automatic fill_window(input logic [reg_data_bits-1:0] base);
		logic [reg_addr_bits-1:0] a;
		for (int w = 0; w < ts_pkt_words; w++) begin
			a = addr_data_base + reg_addr_bits'(w);
			write_reg(a, base ^ {a, ~a, a ^ 8'h5a, a + 8'd1});
		end
	endtask

	task automatic send_packet(input logic [ts_pid_bits-1:0] pid);
		logic [7:0] pkt [ts_pkt_bytes];
		logic [7:0] exp;
		int win;
		pkt[0] = ts_sync_byte;
		pkt[1] = {3'b000, pid[ts_pid_bits-1:8]};
		pkt[2] = pid[7:0];
		for (int k = 3; k < ts_pkt_bytes; k++) begin
			pkt[k] = 8'($urandom);
		end
		// lowest matching replacer takes the packet
		win = -1;
		for (int r = num_replacers - 1; r >= 0; r--) begin
			if (en_m[r + 1] && pid_m[r + 1].f.pid_valid && pid_m[r + 1].f.pid == pid) begin
				win = r;
			end
		end
		for (int k = 0; k < ts_pkt_bytes; k++) begin
			exp = pkt[k];
			if (win >= 0 && k != 0) begin
				exp = rep_m[win][k / 4][8 * (k % 4) +: 8];
			end
			pkt_q.push_back({1'b1, k == 0, exp});
		end
		if (en_m[0] && pid_m[0].f.pid_valid && pid_m[0].f.pid == pid) begin
			cap_m = pkt;
		end
		for (int k = 0; k < ts_pkt_bytes; k++) begin
			@(posedge clk);
			ts_in_valid <= 1'b1;
			ts_in_sync <= (k == 0);
			ts_in_data <= pkt[k];
		end
		@(posedge clk);
		ts_in_valid <= 1'b0;
		ts_in_sync <= 1'b0;
	endtask

	task automatic dump_and_verify();
		logic [reg_data_bits-1:0] got;
		logic [reg_data_bits-1:0] want;
		write_reg(addr_dump, 32'd1);
		got = 32'd1;
		while (got !== 32'd0) begin
			read_reg(addr_dump, got);
		end
		for (int w = 0; w < ts_pkt_words; w++) begin
			want = {cap_m[4 * w + 3], cap_m[4 * w + 2], cap_m[4 * w + 1], cap_m[4 * w]};
			read_reg(addr_data_base + reg_addr_bits'(w), got);
			check_word($sformatf("rdata[window %0d]", w), want, got);
		end
	endtask

	// each input cycle shows up at the output four cycles later
	always @(negedge clk) begin
		logic [9:0] want;
		if (rst_n) begin
			line_q.push_back(ts_in_valid ? pkt_q.pop_front() : 10'b0);
			want = line_q.pop_front();
			check_flag("ts_out_valid", want[9], ts_out_valid);
			check_flag("ts_out_sync", want[8], ts_out_sync);
			if (want[9]) begin
				check_byte("ts_out", want[7:0], ts_out);
			end
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: trace not finished after %0d cycles", limit_cycles);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int fd;
		int lines;
		logic [7:0] cmd;
		logic [8*160-1:0] text;
		logic [31:0] a;
		logic [31:0] d;
		logic [reg_data_bits-1:0] got;
		void'($urandom(32'hea85a612));
		clk = 1'b0;
		rst_n = 1'b0;
		wen = 1'b0;
		waddr = '0;
		wdata = '0;
		ren = 1'b0;
		raddr = '0;
		ts_in_data = '0;
		ts_in_valid = 1'b0;
		ts_in_sync = 1'b0;
		slot_m = '0;
		en_m = '0;
		for (int i = 0; i < num_slots; i++) begin
			pid_m[i] = '0;
		end
		repeat (ts_repl_latency + 1) line_q.push_back(10'b0);
		fd = $fopen("tsp_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open tsp_trace.txt");
			$display("STATUS: FAIL");
			$fatal(1, "trace file missing");
		end
		lines = 0;
		while ($fgets(text, fd) != 0) begin
			lines++;
		end
		$fclose(fd);
		limit_cycles = (lines + 1) * cycles_per_line;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		fd = $fopen("tsp_trace.txt", "r");
		while ($fscanf(fd, " %c", cmd) == 1) begin
			if (cmd == "#") begin
				void'($fgets(text, fd));
			end else if (cmd == "W") begin
				void'($fscanf(fd, "%h %h", a, d));
				write_reg(a[reg_addr_bits-1:0], d);
			end else if (cmd == "R") begin
				void'($fscanf(fd, "%h %h", a, d));
				read_reg(a[reg_addr_bits-1:0], got);
				check_word($sformatf("rdata[%h]", a[reg_addr_bits-1:0]), d, got);
			end else if (cmd == "P") begin
				void'($fscanf(fd, "%h", a));
				send_packet(a[ts_pid_bits-1:0]);
			end else if (cmd == "F") begin
				void'($fscanf(fd, "%h", d));
				fill_window(d);
			end else if (cmd == "D") begin
				dump_and_verify();
			end else begin
				$display("unknown trace command %c", cmd);
				$display("STATUS: FAIL");
				$fatal(1, "bad trace line");
			end
		end
		$fclose(fd);
		// let the last bytes leave the pipeline
		repeat (ts_repl_latency + 5) @(posedge clk);
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* tsp_trace.txt */
# cmd W addr data, R addr expected, P pid, D dump and check window, F fill base
# all values hex, F fills the data window of the current slot
R 00 00000000
W 00 00000005
R 00 00000000
R 07 E0000007
P 0ABC
W 00 00000000
W 01 00010ABC
W 02 00000001
R 01 00010ABC
R 02 00000001
W 00 00000001
W 01 00010ABC
W 02 00000001
F 11000000
P 0ABC
P 0123
W 00 00000002
R 00 00000002
W 01 00010ABC
W 02 00000001
F 22000000
P 0ABC
W 00 00000001
W 02 00000000
R 02 00000000
P 0ABC
R 04 00000002
W 00 00000002
R 04 00000002
W 00 00000000
R 04 00000003
P 0123
D

/* compile.f */
ts_pkg.sv
tsp_regs_pkg.sv
ts_monitor.sv
ts_replacer.sv
tsp_ram.sv
tsp_top.sv
tb_tsp.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -f compile.f --top-module tb_tsp -o tb_tsp

./obj_dir/tb_tsp > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
